// ==== common/mcont_pkg.sv ====
// Memory map, SPI timing and command/result field layout for the protocol controller
// Referenced by scope from every controller module

package mcont_pkg;

	// Data memory geometry
	localparam int MEM_WORDS = 512;
	localparam int ADDR_W = 9;

	// Word address type, also used to size base offsets
	typedef logic [ADDR_W-1:0] addr_t;

	// Command mailbox, one word per slot
	localparam int NUM_SLOTS = 8;
	localparam int SLOT_W = $clog2(NUM_SLOTS);
	localparam addr_t SLOT_BASE = addr_t'(256);

	// Result words follow the slots, same index
	localparam addr_t RESULT_BASE = addr_t'(264);

	// Slave selects and interrupt lines
	localparam int NUM_SS = 4;
	localparam int SS_W = $clog2(NUM_SS);

	// SCK half period in clock cycles
	localparam int SCK_HALF = 2;
	localparam int HALF_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SCK_HALF - 1);

	// Command word fields
	// Tx byte in bits 7..0
	localparam int GO_BIT = 31;
	localparam int SS_LSB = 24;

	// Result word fields
	// Rx byte in bits 7..0, slave select echoed at SS_LSB
	localparam int DONE_BIT = 31;

	// Command fetch FSM
	typedef enum logic [1:0] {
		READ,
		CHECK,
		CLAIM,
		HAND
	} fetch_state_e;

	// SPI shift FSM
	typedef enum logic [1:0] {
		IDLE,
		SELECT,
		SHIFT,
		RELEASE
	} spi_state_e;

endpackage

// ==== filelist.f ====
common/mcont_pkg.sv
hdl/data_mem.sv
mcont/cmd_fetch.sv
mcont/spi_engine.sv
mcont/result_writer.sv
mcont/mcont.sv
hdl/proto_subsys.sv
testbench/spi_slave_model.sv
testbench/tb_proto_subsys.sv

// ==== hdl/data_mem.sv ====
// Dual-port data memory with byte write enables
// Port A serves the host, port B the protocol controller
`timescale 1ns/1ns

module data_mem (
	input  logic                          CLK_BUF,

	// Host port
	input  logic [mcont_pkg::ADDR_W-1:0]  a_addr_i,
	input  logic [3:0]                    a_we_i,
	input  logic [31:0]                   a_wdata_i,
	output logic [31:0]                   a_rdata_o,

	// Controller port
	input  logic [mcont_pkg::ADDR_W-1:0]  b_addr_i,
	input  logic [3:0]                    b_we_i,
	input  logic [31:0]                   b_wdata_i,
	output logic [31:0]                   b_rdata_o
);

	// Word array, contents undefined after power-up
	logic [31:0] mem_q [0:mcont_pkg::MEM_WORDS-1];

	always_ff @(posedge CLK_BUF) begin
		// Read-first on both ports
		a_rdata_o <= mem_q[a_addr_i];
		b_rdata_o <= mem_q[b_addr_i];

		// Host byte writes
		for (int i = 0; i < 4; i++) begin
			if (a_we_i[i]) begin
				mem_q[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
			end
		end

		// Controller byte writes
		// Issued last so port B wins on a shared byte
		for (int i = 0; i < 4; i++) begin
			if (b_we_i[i]) begin
				mem_q[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
			end
		end
	end

endmodule

// ==== hdl/proto_subsys.sv ====
// Protocol subsystem top: shared data memory plus SPI protocol controller
// Host drives port A, controller fetches commands through port B
`timescale 1ns/1ns

module proto_subsys (
	input  logic                          CLK_BUF,
	input  logic                          reset_i,

	// Host memory port
	input  logic [mcont_pkg::ADDR_W-1:0]  host_addr_i,
	input  logic [3:0]                    host_we_i,
	input  logic [31:0]                   host_wdata_i,
	output logic [31:0]                   host_rdata_o,

	// SPI pins
	output logic                          sck_o,
	output logic                          mosi_o,
	input  logic                          miso_i,
	output logic [mcont_pkg::NUM_SS-1:0]  ss_n_o,

	output logic [mcont_pkg::NUM_SS-1:0]  int_o
);

	// Controller side of the memory
	logic [mcont_pkg::ADDR_W-1:0]  con_addr;
	logic [3:0]                    con_we;
	logic [31:0]                   con_wdata;
	logic [31:0]                   con_rdata;

	data_mem i_data_mem (
		.CLK_BUF   (CLK_BUF),
		.a_addr_i  (host_addr_i),
		.a_we_i    (host_we_i),
		.a_wdata_i (host_wdata_i),
		.a_rdata_o (host_rdata_o),
		.b_addr_i  (con_addr),
		.b_we_i    (con_we),
		.b_wdata_i (con_wdata),
		.b_rdata_o (con_rdata)
	);

	mcont i_mcont (
		.CLK_BUF     (CLK_BUF),
		.reset_i     (reset_i),
		.mem_addr_o  (con_addr),
		.mem_we_o    (con_we),
		.mem_wdata_o (con_wdata),
		.mem_rdata_i (con_rdata),
		.sck_o       (sck_o),
		.mosi_o      (mosi_o),
		.miso_i      (miso_i),
		.ss_n_o      (ss_n_o),
		.int_o       (int_o)
	);

endmodule

// ==== mcont/cmd_fetch.sv ====
// Round-robin poller over the command slots
// Claims a command by clearing its go bit, then offers it to the SPI engine
`timescale 1ns/1ns

module cmd_fetch (
	input  logic                          CLK_BUF,
	input  logic                          reset_i,

	// Memory port B request
	output logic                          req_o,
	input  logic                          gnt_i,
	output logic [mcont_pkg::ADDR_W-1:0]  addr_o,
	output logic [3:0]                    we_o,
	output logic [31:0]                   wdata_o,
	input  logic [31:0]                   rdata_i,

	// Command hand-off
	output logic                          cmd_valid_o,
	input  logic                          cmd_ready_i,
	output logic [mcont_pkg::SLOT_W-1:0]  cmd_slot_o,
	output logic [mcont_pkg::SS_W-1:0]    cmd_ss_o,
	output logic [7:0]                    cmd_tx_o
);

	mcont_pkg::fetch_state_e        state_q;
	logic [mcont_pkg::SLOT_W-1:0]   slot_q;
	logic [31:0]                    cmd_word_q;
	logic                           go_seen;

	// Read data is valid in CHECK, one cycle after the granted read
	assign go_seen = (state_q == mcont_pkg::CHECK) && rdata_i[mcont_pkg::GO_BIT];

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			state_q <= mcont_pkg::READ;
			slot_q  <= '0;
		end else begin
			case (state_q)
				mcont_pkg::READ: begin
					// Wait out write-back traffic
					if (gnt_i) begin
						state_q <= mcont_pkg::CHECK;
					end
				end
				mcont_pkg::CHECK: begin
					if (go_seen) begin
						state_q <= mcont_pkg::CLAIM;
					end else begin
						// Empty slot, move on
						slot_q  <= slot_q + 1'b1;
						state_q <= mcont_pkg::READ;
					end
				end
				mcont_pkg::CLAIM: begin
					if (gnt_i) begin
						state_q <= mcont_pkg::HAND;
					end
				end
				mcont_pkg::HAND: begin
					// Scan frozen until the engine takes it
					if (cmd_ready_i) begin
						slot_q  <= slot_q + 1'b1;
						state_q <= mcont_pkg::READ;
					end
				end
				default: begin
					state_q <= mcont_pkg::READ;
				end
			endcase
		end
	end

	// Command word kept for write-back and hand-off
	always_ff @(posedge CLK_BUF) begin
		if (go_seen) begin
			cmd_word_q <= rdata_i;
		end
	end

	always_comb begin
		req_o  = (state_q == mcont_pkg::READ) || (state_q == mcont_pkg::CLAIM);
		addr_o = mcont_pkg::SLOT_BASE + mcont_pkg::addr_t'(slot_q);
		// Only the byte holding the go flag is rewritten
		we_o   = 4'b0000;
		if (state_q == mcont_pkg::CLAIM) begin
			we_o = 4'b0001 << (mcont_pkg::GO_BIT / 8);
		end
		wdata_o = cmd_word_q;
		wdata_o[mcont_pkg::GO_BIT] = 1'b0;
	end

	// Hand-off fields
	assign cmd_valid_o = (state_q == mcont_pkg::HAND);
	assign cmd_slot_o  = slot_q;
	assign cmd_ss_o    = cmd_word_q[mcont_pkg::SS_LSB +: mcont_pkg::SS_W];
	assign cmd_tx_o    = cmd_word_q[7:0];

endmodule

// ==== mcont/mcont.sv ====
// Protocol controller: command fetch, SPI engine and result write-back
// Owns memory port B and shares it between fetch and write-back
`timescale 1ns/1ns

module mcont (
	input  logic                          CLK_BUF,
	input  logic                          reset_i,

	// Memory port B
	output logic [mcont_pkg::ADDR_W-1:0]  mem_addr_o,
	output logic [3:0]                    mem_we_o,
	output logic [31:0]                   mem_wdata_o,
	input  logic [31:0]                   mem_rdata_i,

	// SPI pins
	output logic                          sck_o,
	output logic                          mosi_o,
	input  logic                          miso_i,
	output logic [mcont_pkg::NUM_SS-1:0]  ss_n_o,

	// One interrupt per slave select
	output logic [mcont_pkg::NUM_SS-1:0]  int_o
);

	// Fetch side of port B
	logic                          cf_req;
	logic                          cf_gnt;
	logic [mcont_pkg::ADDR_W-1:0]  cf_addr;
	logic [3:0]                    cf_we;
	logic [31:0]                   cf_wdata;

	// Write-back side of port B
	logic                          rw_req;
	logic                          rw_gnt;
	logic [mcont_pkg::ADDR_W-1:0]  rw_addr;
	logic [3:0]                    rw_we;
	logic [31:0]                   rw_wdata;

	// Fetch to engine
	logic                          cmd_valid;
	logic                          cmd_ready;
	logic [mcont_pkg::SLOT_W-1:0]  cmd_slot;
	logic [mcont_pkg::SS_W-1:0]    cmd_ss;
	logic [7:0]                    cmd_tx;

	// Engine to write-back
	logic                          res_valid;
	logic                          res_ready;
	logic [mcont_pkg::SLOT_W-1:0]  res_slot;
	logic [mcont_pkg::SS_W-1:0]    res_ss;
	logic [7:0]                    res_rx;

	// Write-back has priority, it holds the port one cycle per result
	assign rw_gnt = rw_req;
	assign cf_gnt = cf_req & ~rw_req;

	// Port B mux
	assign mem_addr_o  = rw_req ? rw_addr  : cf_addr;
	assign mem_we_o    = rw_req ? rw_we    : cf_we;
	assign mem_wdata_o = rw_req ? rw_wdata : cf_wdata;

	cmd_fetch i_cmd_fetch (
		.CLK_BUF     (CLK_BUF),
		.reset_i     (reset_i),
		.req_o       (cf_req),
		.gnt_i       (cf_gnt),
		.addr_o      (cf_addr),
		.we_o        (cf_we),
		.wdata_o     (cf_wdata),
		.rdata_i     (mem_rdata_i),
		.cmd_valid_o (cmd_valid),
		.cmd_ready_i (cmd_ready),
		.cmd_slot_o  (cmd_slot),
		.cmd_ss_o    (cmd_ss),
		.cmd_tx_o    (cmd_tx)
	);

	spi_engine i_spi_engine (
		.CLK_BUF     (CLK_BUF),
		.reset_i     (reset_i),
		.cmd_valid_i (cmd_valid),
		.cmd_ready_o (cmd_ready),
		.cmd_slot_i  (cmd_slot),
		.cmd_ss_i    (cmd_ss),
		.cmd_tx_i    (cmd_tx),
		.res_valid_o (res_valid),
		.res_ready_i (res_ready),
		.res_slot_o  (res_slot),
		.res_ss_o    (res_ss),
		.res_rx_o    (res_rx),
		.sck_o       (sck_o),
		.mosi_o      (mosi_o),
		.miso_i      (miso_i),
		.ss_n_o      (ss_n_o)
	);

	result_writer i_result_writer (
		.CLK_BUF     (CLK_BUF),
		.reset_i     (reset_i),
		.res_valid_i (res_valid),
		.res_ready_o (res_ready),
		.res_slot_i  (res_slot),
		.res_ss_i    (res_ss),
		.res_rx_i    (res_rx),
		.req_o       (rw_req),
		.gnt_i       (rw_gnt),
		.addr_o      (rw_addr),
		.we_o        (rw_we),
		.wdata_o     (rw_wdata),
		.int_o       (int_o)
	);

endmodule

// ==== mcont/result_writer.sv ====
// One-entry result buffer that writes the result word for its slot
// Pulses the interrupt of the slave select in the cycle the write lands
`timescale 1ns/1ns

module result_writer (
	input  logic                          CLK_BUF,
	input  logic                          reset_i,

	// Result in
	input  logic                          res_valid_i,
	output logic                          res_ready_o,
	input  logic [mcont_pkg::SLOT_W-1:0]  res_slot_i,
	input  logic [mcont_pkg::SS_W-1:0]    res_ss_i,
	input  logic [7:0]                    res_rx_i,

	// Memory port B request, write only
	output logic                          req_o,
	input  logic                          gnt_i,
	output logic [mcont_pkg::ADDR_W-1:0]  addr_o,
	output logic [3:0]                    we_o,
	output logic [31:0]                   wdata_o,

	output logic [mcont_pkg::NUM_SS-1:0]  int_o
);

	logic                           pend_q;
	logic [mcont_pkg::SLOT_W-1:0]   slot_q;
	logic [mcont_pkg::SS_W-1:0]     ss_q;
	logic [7:0]                     rx_q;
	logic                           take;
	logic                           write_now;

	assign take      = res_valid_i && !pend_q;
	assign write_now = pend_q && gnt_i;

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			pend_q <= 1'b0;
		end else if (take) begin
			pend_q <= 1'b1;
		end else if (write_now) begin
			pend_q <= 1'b0;
		end
	end

	always_ff @(posedge CLK_BUF) begin
		if (take) begin
			slot_q <= res_slot_i;
			ss_q   <= res_ss_i;
			rx_q   <= res_rx_i;
		end
	end

	assign res_ready_o = ~pend_q;
	assign req_o       = pend_q;
	assign addr_o      = mcont_pkg::RESULT_BASE + mcont_pkg::addr_t'(slot_q);
	assign we_o        = {4{pend_q}};

	always_comb begin
		// Done flag, echoed select, received byte
		wdata_o = '0;
		wdata_o[mcont_pkg::DONE_BIT] = 1'b1;
		wdata_o[mcont_pkg::SS_LSB +: mcont_pkg::SS_W] = ss_q;
		wdata_o[7:0] = rx_q;

		int_o = '0;
		if (write_now) begin
			int_o[ss_q] = 1'b1;
		end
	end

endmodule

// ==== mcont/spi_engine.sv ====
// SPI mode 0 master, one byte per command, MSB first
// Frame: 2 cycles select, 8 bits of 4 cycles (high then low half), then release
`timescale 1ns/1ns

module spi_engine (
	input  logic                          CLK_BUF,
	input  logic                          reset_i,

	// Command in
	input  logic                          cmd_valid_i,
	output logic                          cmd_ready_o,
	input  logic [mcont_pkg::SLOT_W-1:0]  cmd_slot_i,
	input  logic [mcont_pkg::SS_W-1:0]    cmd_ss_i,
	input  logic [7:0]                    cmd_tx_i,

	// Result out
	output logic                          res_valid_o,
	input  logic                          res_ready_i,
	output logic [mcont_pkg::SLOT_W-1:0]  res_slot_o,
	output logic [mcont_pkg::SS_W-1:0]    res_ss_o,
	output logic [7:0]                    res_rx_o,

	// SPI pins
	output logic                          sck_o,
	output logic                          mosi_o,
	input  logic                          miso_i,
	output logic [mcont_pkg::NUM_SS-1:0]  ss_n_o
);

	mcont_pkg::spi_state_e          state_q;
	logic [mcont_pkg::HALF_W-1:0]   half_q;
	logic [2:0]                     bit_q;
	logic                           sck_q;
	logic [7:0]                     tx_sr_q;
	logic [7:0]                     rx_sr_q;
	logic [mcont_pkg::SLOT_W-1:0]   slot_q;
	logic [mcont_pkg::SS_W-1:0]     ss_q;
	logic                           accept;
	logic                           half_end;
	logic                           in_frame;
	logic                           rise_edge;
	logic                           fall_edge;

	assign accept   = (state_q == mcont_pkg::IDLE) && cmd_valid_i;
	assign half_end = (half_q == mcont_pkg::HALF_LAST);
	assign in_frame = (state_q == mcont_pkg::SELECT) || (state_q == mcont_pkg::SHIFT);

	// SCK rises at end of select and after every low half but the last
	assign rise_edge = half_end && ((state_q == mcont_pkg::SELECT) ||
		((state_q == mcont_pkg::SHIFT) && !sck_q && (bit_q != 3'd7)));
	assign fall_edge = half_end && (state_q == mcont_pkg::SHIFT) && sck_q;

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			state_q <= mcont_pkg::IDLE;
			half_q  <= '0;
			bit_q   <= '0;
			sck_q   <= 1'b0;
		end else begin
			case (state_q)
				mcont_pkg::IDLE: begin
					if (accept) begin
						state_q <= mcont_pkg::SELECT;
						half_q  <= '0;
						bit_q   <= '0;
					end
				end
				mcont_pkg::SELECT: begin
					half_q <= half_end ? '0 : half_q + 1'b1;
					if (half_end) begin
						sck_q   <= 1'b1;
						state_q <= mcont_pkg::SHIFT;
					end
				end
				mcont_pkg::SHIFT: begin
					half_q <= half_end ? '0 : half_q + 1'b1;
					if (fall_edge) begin
						sck_q <= 1'b0;
					end else if (rise_edge) begin
						sck_q <= 1'b1;
						bit_q <= bit_q + 1'b1;
					end else if (half_end) begin
						// Trailing low half of bit 0 done
						state_q <= mcont_pkg::RELEASE;
					end
				end
				mcont_pkg::RELEASE: begin
					// Held here while write-back is busy
					if (res_ready_i) begin
						state_q <= mcont_pkg::IDLE;
					end
				end
				default: begin
					state_q <= mcont_pkg::IDLE;
				end
			endcase
		end
	end

	// Shift registers and command fields
	always_ff @(posedge CLK_BUF) begin
		if (accept) begin
			tx_sr_q <= cmd_tx_i;
			slot_q  <= cmd_slot_i;
			ss_q    <= cmd_ss_i;
		end else if (fall_edge) begin
			tx_sr_q <= {tx_sr_q[6:0], 1'b0};
		end
		if (rise_edge) begin
			rx_sr_q <= {rx_sr_q[6:0], miso_i};
		end
	end

	// Decoded select, active low during the frame only
	always_comb begin
		ss_n_o = '1;
		if (in_frame) begin
			ss_n_o[ss_q] = 1'b0;
		end
	end

	assign sck_o  = sck_q;
	assign mosi_o = in_frame & tx_sr_q[7];

	assign cmd_ready_o = (state_q == mcont_pkg::IDLE);
	assign res_valid_o = (state_q == mcont_pkg::RELEASE);
	assign res_slot_o  = slot_q;
	assign res_ss_o    = ss_q;
	assign res_rx_o    = rx_sr_q;

endmodule

// ==== testbench/spi_slave_model.sv ====
// Four behavioral SPI mode 0 slaves sharing SCK, MOSI and MISO
// Each slave replies with its previous received byte XOR 0x5A, or zero on its first frame
`timescale 1ns/1ns

module spi_slave_model (
	input  logic                                sck_i,
	input  logic                                mosi_i,
	output logic                                miso_o,
	input  logic [mcont_pkg::NUM_SS-1:0]        ss_n_i,
	// Last completed received byte per slave
	output logic [mcont_pkg::NUM_SS-1:0][7:0]   cap_byte_o
);

	logic [7:0]                    rx_sr [mcont_pkg::NUM_SS];
	logic [7:0]                    tx_sr [mcont_pkg::NUM_SS];
	logic                          first_frame [mcont_pkg::NUM_SS];
	logic                          in_frame [mcont_pkg::NUM_SS];
	logic [mcont_pkg::NUM_SS-1:0]  ss_n_prev;

	// Only the selected slave drives the shared MISO line
	task automatic drive_miso();
		miso_o = 1'b0;
		for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
			if (in_frame[n]) begin
				miso_o = tx_sr[n][7];
			end
		end
	endtask

	initial begin
		miso_o    = 1'b0;
		ss_n_prev = '1;
		for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
			first_frame[n] = 1'b1;
			in_frame[n]    = 1'b0;
			rx_sr[n]       = 8'h00;
			tx_sr[n]       = 8'h00;
			cap_byte_o[n]  = 8'h00;
		end
	end

	// Frame start loads the reply, frame end keeps the received byte
	always @(ss_n_i) begin
		for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
			if (ss_n_prev[n] === 1'b1 && ss_n_i[n] === 1'b0) begin
				in_frame[n] = 1'b1;
				rx_sr[n]    = 8'h00;
				tx_sr[n]    = first_frame[n] ? 8'h00 : (cap_byte_o[n] ^ 8'h5A);
			end else if (ss_n_prev[n] === 1'b0 && ss_n_i[n] === 1'b1 && in_frame[n]) begin
				cap_byte_o[n]  = rx_sr[n];
				first_frame[n] = 1'b0;
				in_frame[n]    = 1'b0;
			end
		end
		ss_n_prev = ss_n_i;
		drive_miso();
	end

	// Mode 0: sample on rising SCK
	always @(posedge sck_i) begin
		for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
			if (in_frame[n]) begin
				rx_sr[n] = {rx_sr[n][6:0], mosi_i};
			end
		end
	end

	// Next reply bit on falling SCK
	always @(negedge sck_i) begin
		for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
			if (in_frame[n]) begin
				tx_sr[n] = {tx_sr[n][6:0], 1'b0};
			end
		end
		drive_miso();
	end

endmodule

// ==== testbench/tb_proto_subsys.sv ====
// Random command testbench for the protocol subsystem with host port and SPI slave models
// Issues commands into free slots and checks each result after its interrupt
`timescale 1ns/1ns

module tb_proto_subsys;

	localparam int NUM_CMDS       = 60;
	localparam int CYCLES_PER_CMD = 200;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * CYCLES_PER_CMD + 2000;
	localparam int RESET_CYCLES   = 5;
	localparam int IDLE_CYCLES    = 20;

	logic                                CLK_BUF;
	logic                                reset_i;
	logic [mcont_pkg::ADDR_W-1:0]        host_addr_i;
	logic [3:0]                          host_we_i;
	logic [31:0]                         host_wdata_i;
	logic [31:0]                         host_rdata_o;
	logic                                sck_o;
	logic                                mosi_o;
	logic                                miso_i;
	logic [mcont_pkg::NUM_SS-1:0]        ss_n_o;
	logic [mcont_pkg::NUM_SS-1:0]        int_o;
	logic [mcont_pkg::NUM_SS-1:0][7:0]   cap_byte;

	// Reference model with at most one outstanding command per slave select
	bit   [mcont_pkg::NUM_SS-1:0]        ss_busy;
	bit   [mcont_pkg::NUM_SLOTS-1:0]     slot_busy;
	int                                  slot_of_ss [mcont_pkg::NUM_SS];
	logic [31:0]                         cmd_of_ss [mcont_pkg::NUM_SS];
	logic [7:0]                          tx_of_ss [mcont_pkg::NUM_SS];
	logic [7:0]                          exp_rx_of_ss [mcont_pkg::NUM_SS];
	logic [7:0]                          prev_tx [mcont_pkg::NUM_SS];
	bit                                  have_prev [mcont_pkg::NUM_SS];
	int                                  int_cnt [mcont_pkg::NUM_SS];
	int                                  frames_done [mcont_pkg::NUM_SS];
	int                                  serviced_cnt [mcont_pkg::NUM_SS];
	logic [mcont_pkg::NUM_SS-1:0]        ss_prev;
	int                                  cycle_cnt;
	int                                  issued;
	int                                  completed;
	bit                                  serviced_any;

	proto_subsys i_dut (
		.CLK_BUF      (CLK_BUF),
		.reset_i      (reset_i),
		.host_addr_i  (host_addr_i),
		.host_we_i    (host_we_i),
		.host_wdata_i (host_wdata_i),
		.host_rdata_o (host_rdata_o),
		.sck_o        (sck_o),
		.mosi_o       (mosi_o),
		.miso_i       (miso_i),
		.ss_n_o       (ss_n_o),
		.int_o        (int_o)
	);

	spi_slave_model i_slaves (
		.sck_i      (sck_o),
		.mosi_i     (mosi_o),
		.miso_o     (miso_i),
		.ss_n_i     (ss_n_o),
		.cap_byte_o (cap_byte)
	);

	always #10 CLK_BUF = ~CLK_BUF;

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input string what);
		if (act !== exp) begin
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, act, exp));
		end
	endtask

	task automatic check_ss(input logic [mcont_pkg::SS_W-1:0] act,
		input logic [mcont_pkg::SS_W-1:0] exp, input string what);
		if (act !== exp) begin
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
				$time, what, act, exp));
		end
	endtask

	task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string what);
		if (act !== exp) begin
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, act, exp));
		end
	endtask

	task automatic check_lines(input logic [mcont_pkg::NUM_SS-1:0] act,
		input logic [mcont_pkg::NUM_SS-1:0] exp, input string what);
		if (act !== exp) begin
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, what, act, exp));
		end
	endtask

	task automatic check_bit(input logic act, input logic exp, input string what);
		if (act !== exp) begin
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, what, act, exp));
		end
	endtask

	// Host port A write lasting one cycle
	task automatic host_write(input logic [mcont_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
		@(posedge CLK_BUF);
		host_addr_i  <= addr;
		host_we_i    <= 4'hF;
		host_wdata_i <= data;
		@(posedge CLK_BUF);
		host_we_i    <= 4'h0;
	endtask

	// Read data valid one cycle after the address is sampled
	task automatic host_read(input logic [mcont_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
		@(posedge CLK_BUF);
		host_addr_i <= addr;
		host_we_i   <= 4'h0;
		@(posedge CLK_BUF);
		@(posedge CLK_BUF);
		data = host_rdata_o;
	endtask

	task automatic issue_command();
		int          ss;
		int          slot;
		logic [31:0] word;
		logic [7:0]  tx;
		ss = $urandom % mcont_pkg::NUM_SS;
		while (ss_busy[ss]) begin
			ss = $urandom % mcont_pkg::NUM_SS;
		end
		slot = $urandom % mcont_pkg::NUM_SLOTS;
		while (slot_busy[slot]) begin
			slot = $urandom % mcont_pkg::NUM_SLOTS;
		end
		// Random filler in unused bits that must survive the claim
		tx   = $urandom;
		word = $urandom;
		word[mcont_pkg::GO_BIT] = 1'b1;
		word[mcont_pkg::SS_LSB +: mcont_pkg::SS_W] = ss[mcont_pkg::SS_W-1:0];
		word[7:0] = tx;
		// Reply rule of the addressed slave
		exp_rx_of_ss[ss] = have_prev[ss] ? (prev_tx[ss] ^ 8'h5A) : 8'h00;
		prev_tx[ss]      = tx;
		have_prev[ss]    = 1'b1;
		slot_of_ss[ss]   = slot;
		cmd_of_ss[ss]    = word;
		tx_of_ss[ss]     = tx;
		ss_busy[ss]      = 1'b1;
		slot_busy[slot]  = 1'b1;
		host_write(mcont_pkg::SLOT_BASE + mcont_pkg::addr_t'(slot), word);
	endtask

	task automatic service_result(input int n);
		logic [31:0]                  rd;
		logic [31:0]                  exp;
		logic [mcont_pkg::SS_W-1:0]   ss_val;
		ss_val = n[mcont_pkg::SS_W-1:0];
		exp = '0;
		exp[mcont_pkg::DONE_BIT] = 1'b1;
		exp[mcont_pkg::SS_LSB +: mcont_pkg::SS_W] = ss_val;
		exp[7:0] = exp_rx_of_ss[n];
		host_read(mcont_pkg::RESULT_BASE + mcont_pkg::addr_t'(slot_of_ss[n]), rd);
		check_byte(rd[7:0], exp_rx_of_ss[n], "received byte");
		check_ss(rd[mcont_pkg::SS_LSB +: mcont_pkg::SS_W], ss_val, "echoed slave select");
		check_word(rd, exp, "result word");
		// Command must read back with only the go bit cleared
		exp = cmd_of_ss[n];
		exp[mcont_pkg::GO_BIT] = 1'b0;
		host_read(mcont_pkg::SLOT_BASE + mcont_pkg::addr_t'(slot_of_ss[n]), rd);
		check_word(rd, exp, "command word after run");
		slot_busy[slot_of_ss[n]] = 1'b0;
		ss_busy[n] = 1'b0;
		serviced_cnt[n]++;
		completed++;
	endtask

	// Run limit
	always @(posedge CLK_BUF) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			stop_with_error("Timeout: not all commands finished within the cycle limit");
		end
	end

	// Frame and interrupt monitor
	always @(posedge CLK_BUF) begin
		if (!reset_i) begin
			if ($countones(~ss_n_o) > 1) begin
				stop_with_error("More than one slave select is low at the same time");
			end
			for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
				if (ss_n_o[n] === 1'b0 && !ss_busy[n]) begin
					stop_with_error($sformatf("Slave select %0d went low with no command", n));
				end
				// Frame end leaves the sent byte in the slave
				if (ss_prev[n] === 1'b0 && ss_n_o[n] === 1'b1) begin
					if (frames_done[n] != serviced_cnt[n]) begin
						stop_with_error($sformatf("Extra frame on slave select %0d", n));
					end
					check_byte(cap_byte[n], tx_of_ss[n], "byte seen by slave");
					frames_done[n]++;
				end
				if (int_o[n] === 1'b1) begin
					if (!ss_busy[n] || int_cnt[n] != serviced_cnt[n] ||
						frames_done[n] != serviced_cnt[n] + 1) begin
						stop_with_error($sformatf("Unexpected interrupt on line %0d", n));
					end
					int_cnt[n]++;
				end
			end
		end
		ss_prev = ss_n_o;
	end

	initial begin
		CLK_BUF      = 1'b0;
		reset_i      = 1'b1;
		host_addr_i  = '0;
		host_we_i    = 4'h0;
		host_wdata_i = 32'h0;
		cycle_cnt    = 0;
		issued       = 0;
		completed    = 0;
		ss_busy      = '0;
		slot_busy    = '0;
		ss_prev      = '1;
		for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
			int_cnt[n]      = 0;
			frames_done[n]  = 0;
			serviced_cnt[n] = 0;
			have_prev[n]    = 1'b0;
		end
		void'($urandom(30));

		// Slots cleared through the host port while reset runs for 5 cycles
		for (int i = 0; i < mcont_pkg::NUM_SLOTS; i++) begin
			@(posedge CLK_BUF);
			host_addr_i  <= mcont_pkg::SLOT_BASE + mcont_pkg::addr_t'(i);
			host_we_i    <= 4'hF;
			host_wdata_i <= 32'h0;
			if (i == RESET_CYCLES - 1) begin
				reset_i <= 1'b0;
			end
		end
		@(posedge CLK_BUF);
		host_we_i <= 4'h0;

		// Quiet outputs before any go bit
		repeat (IDLE_CYCLES) begin
			@(posedge CLK_BUF);
			check_lines(ss_n_o, '1, "ss_n_o while idle");
			check_lines(int_o, '0, "int_o while idle");
			check_bit(sck_o, 1'b0, "sck_o while idle");
			check_bit(mosi_o, 1'b0, "mosi_o while idle");
		end

		// Pending interrupts served before any new command
		while (completed < NUM_CMDS) begin
			serviced_any = 1'b0;
			for (int n = 0; n < mcont_pkg::NUM_SS; n++) begin
				if (int_cnt[n] > serviced_cnt[n]) begin
					service_result(n);
					serviced_any = 1'b1;
				end
			end
			if (issued < NUM_CMDS && ss_busy != '1 && ($urandom % 4) != 0) begin
				issue_command();
				issued++;
			end else if (!serviced_any) begin
				@(posedge CLK_BUF);
			end
		end

		// Quiet tail for the monitor to catch stray frames or interrupts
		repeat (100) @(posedge CLK_BUF);
		$display("PASS: all tests");
		$finish;
	end

endmodule
